// ==== src/topDistPkg.sv ====
package topDistPkg;

    // Size of one configuration word.
    localparam int TOP_WIDTH = 128;

    // Width of the serial channel, which is one data wire and one control wire.
    localparam int CHANNEL_WIDTH = 2;

    // Step counter covers 256 half-bit steps plus the done bit on top.
    localparam int INDEX_WIDTH = 9;

    // Bits of the step counter that pick the bit index, dropping the half-bit step.
    localparam int BIT_SEL_WIDTH = INDEX_WIDTH - 2;

    // Cycles after a new top during which pipelineIsEmpty is not trusted.
    localparam int WARMUP_CYCLES = 15;
    localparam int WARMUP_WIDTH = $clog2(WARMUP_CYCLES + 1);

    // Settling time from the last bit until doneTransmitting rises.
    // It must exceed the slowest receiver's route plus capture latency.
    localparam int DONE_DELAY = 12;

    // Receivers on the channel.
    localparam int NUM_RECEIVERS = 4;

    // Route stages in front of receiver 0. Each further receiver adds one stage.
    localparam int ROUTE_BASE_STAGES = 1;

    // One sample of the channel, data in the upper bit and control in the lower bit.
    typedef logic [CHANNEL_WIDTH-1:0] channelT;

endpackage

// ==== src/delayLine.sv ====
`timescale 1ns/1ps

module delayLine #(
    parameter type dataType = logic,
    parameter int depth = 1
) (
    input  logic    clk,
    input  logic    rst,
    input  dataType in,
    output dataType out
);

    dataType stages [depth]; // Stage 0 takes the input, the last stage drives out.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= in;
            for (int i = 1; i < depth; i++) begin
                stages[i] <= stages[i-1]; // Each value moves one stage per cycle.
            end
        end
    end

    assign out = stages[depth-1];

endmodule

// ==== src/topTransmitter.sv ====
`timescale 1ns/1ps

module topTransmitter import topDistPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [TOP_WIDTH-1:0] top,
    input  logic                 transmitTop,
    output logic                 doneTransmitting,
    output channelT              topChannel
);

    // Two steps per bit; the top bit of the counter marks the done state.
    logic [INDEX_WIDTH-1:0]   curIndex;
    logic                     indexDone;
    logic [BIT_SEL_WIDTH-1:0] bitSelector;
    logic                     controlState;
    logic                     topBitstream;

    assign indexDone   = curIndex[INDEX_WIDTH-1];
    assign bitSelector = curIndex[INDEX_WIDTH-2:1]; // Least significant bit goes first.

    always_ff @(posedge clk) begin
        if (rst) begin
            curIndex <= {1'b1, {(INDEX_WIDTH-1){1'b0}}}; // Idle in the done state.
        end else if (transmitTop) begin
            curIndex <= '0; // Held at the start until transmitTop drops.
        end else if (!indexDone) begin
            curIndex <= curIndex + 1'b1;
        end
    end

    // Odd steps flip the control wire, so each bit is stable for a cycle before its edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            controlState <= 1'b0;
        end else if (curIndex[0]) begin
            controlState <= !controlState;
        end
    end

    always_ff @(posedge clk) begin
        topBitstream <= top[bitSelector];
    end

    assign topChannel = {topBitstream, controlState};

    // Gives every receiver time to install the last bit before the manager moves on.
    delayLine #(
        .dataType(logic),
        .depth   (DONE_DELAY)
    ) donePipe (
        .clk(clk),
        .rst(rst),
        .in (indexDone),
        .out(doneTransmitting)
    );

endmodule

// ==== src/topReceiver.sv ====
`timescale 1ns/1ps

module topReceiver import topDistPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  channelT              topChannel,
    output logic [TOP_WIDTH-1:0] top
);

    logic data;
    logic control;
    logic prevControl;
    logic dataD;
    logic dataDD;
    logic transmitD;
    logic transmitDD;

    // Input register gives the long route some extra slack.
    always_ff @(posedge clk) begin
        if (rst) begin
            control     <= 1'b0;
            prevControl <= 1'b0;
            transmitD   <= 1'b0;
            transmitDD  <= 1'b0;
        end else begin
            control     <= topChannel[0];
            prevControl <= control;
            transmitD   <= control ^ prevControl; // A bit is taken on every control toggle.
            transmitDD  <= transmitD;
        end
    end

    // Data follows the same two stages as the toggle detection.
    always_ff @(posedge clk) begin
        data   <= topChannel[1];
        dataD  <= data;
        dataDD <= dataD;
    end

    // Shifting in from the top puts the first bit at index 0 after a full word.
    always_ff @(posedge clk) begin
        if (rst) begin
            top <= '0;
        end else if (transmitDD) begin
            top <= {dataDD, top[TOP_WIDTH-1:1]};
        end
    end

endmodule

// ==== src/topManager.sv ====
`timescale 1ns/1ps

module topManager import topDistPkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [TOP_WIDTH-1:0] topIn,
    input  logic                 topInValid,
    output logic                 stallInput,
    input  logic                 pipelineIsEmpty,
    output logic                 transmitTop,
    output logic [TOP_WIDTH-1:0] top,
    input  logic                 doneTransmitting
);

    logic [TOP_WIDTH-1:0]    topInWaiting;
    logic                    isTopInWaiting;
    logic [WARMUP_WIDTH-1:0] cyclesSinceTopStart;
    logic                    newTopWarmingUp;

    assign newTopWarmingUp = cyclesSinceTopStart != WARMUP_CYCLES[WARMUP_WIDTH-1:0];

    // pipelineIsEmpty may still reflect the old top for a while after a new one arrives.
    always_ff @(posedge clk) begin
        if (rst || topInValid) begin
            cyclesSinceTopStart <= '0;
        end else if (newTopWarmingUp) begin
            cyclesSinceTopStart <= cyclesSinceTopStart + 1'b1;
        end
    end

    // Keep the transmitter parked at its start while the pipeline is still busy.
    always_ff @(posedge clk) begin
        if (rst) begin
            transmitTop <= 1'b0;
        end else begin
            transmitTop <= isTopInWaiting && (!pipelineIsEmpty || newTopWarmingUp);
        end
    end

    // A new top always wins, even over one that is halfway out.
    always_ff @(posedge clk) begin
        if (rst) begin
            isTopInWaiting <= 1'b0;
        end else if (topInValid) begin
            isTopInWaiting <= 1'b1;
        end else if (doneTransmitting && !newTopWarmingUp) begin
            isTopInWaiting <= 1'b0; // Stale done from the previous top is masked by warm-up.
        end
    end

    always_ff @(posedge clk) begin
        if (topInValid) begin
            topInWaiting <= topIn;
        end
    end

    assign top        = topInWaiting;
    assign stallInput = isTopInWaiting;

endmodule

// ==== src/topDistribution.sv ====
`timescale 1ns/1ps

module topDistribution import topDistPkg::*; (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic [TOP_WIDTH-1:0]                     topIn,
    input  logic                                     topInValid,
    output logic                                     stallInput,
    input  logic                                     pipelineIsEmpty,
    output logic [NUM_RECEIVERS-1:0][TOP_WIDTH-1:0] receivedTops
);

    logic                 transmitTop;
    logic [TOP_WIDTH-1:0] pendingTop;
    logic                 doneTransmitting;
    channelT              topChannel;
    channelT              routedChannel [NUM_RECEIVERS]; // Channel as seen at each receiver.

    topManager manager (
        .clk             (clk),
        .rst             (rst),
        .topIn           (topIn),
        .topInValid      (topInValid),
        .stallInput      (stallInput),
        .pipelineIsEmpty (pipelineIsEmpty),
        .transmitTop     (transmitTop),
        .top             (pendingTop),
        .doneTransmitting(doneTransmitting)
    );

    topTransmitter transmitter (
        .clk             (clk),
        .rst             (rst),
        .top             (pendingTop),
        .transmitTop     (transmitTop),
        .doneTransmitting(doneTransmitting),
        .topChannel      (topChannel)
    );

    for (genvar i = 0; i < NUM_RECEIVERS; i++) begin : genReceivers
        // Farther receivers sit behind more route registers.
        delayLine #(
            .dataType(channelT),
            .depth   (ROUTE_BASE_STAGES + i)
        ) route (
            .clk(clk),
            .rst(rst),
            .in (topChannel),
            .out(routedChannel[i])
        );

        topReceiver receiver (
            .clk       (clk),
            .rst       (rst),
            .topChannel(routedChannel[i]),
            .top       (receivedTops[i])
        );
    end

endmodule

// ==== verif/topDistributionTb.sv ====
`timescale 1ns/1ps

module topDistributionTb import topDistPkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int BACK_TO_BACK_TOPS = 60;

    logic                                    clk;
    logic                                    rst;
    logic [TOP_WIDTH-1:0]                    topIn;
    logic                                    topInValid;
    logic                                    stallInput;
    logic                                    pipelineIsEmpty;
    logic [NUM_RECEIVERS-1:0][TOP_WIDTH-1:0] receivedTops;

    logic [31:0]          rngState;
    logic [TOP_WIDTH-1:0] expectedTop; // Last accepted top, which every receiver must end up with.

    topDistribution uut (
        .clk            (clk),
        .rst            (rst),
        .topIn          (topIn),
        .topInValid     (topInValid),
        .stallInput     (stallInput),
        .pipelineIsEmpty(pipelineIsEmpty),
        .receivedTops   (receivedTops)
    );

    always #10 clk = !clk; // 20 ns period.

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic int unsigned randomBetween(input int unsigned lo, input int unsigned hi);
        return lo + (nextRandom() % (hi - lo + 1));
    endfunction

    function automatic logic [TOP_WIDTH-1:0] randomTop();
        return {nextRandom(), nextRandom(), nextRandom(), nextRandom()};
    endfunction

    task automatic failRun();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    // Outputs are read and inputs driven 1 ns after the rising edge.
    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic checkStall(input logic expected);
        assert (stallInput === expected) else begin
            $display("Error: time %0t stallInput expected %0b got %0b",
                     $time, expected, stallInput);
            failRun();
        end
    endtask

    task automatic checkReceivers(input logic [TOP_WIDTH-1:0] expected);
        for (int i = 0; i < NUM_RECEIVERS; i++) begin
            assert (receivedTops[i] === expected) else begin
                $display("Error: time %0t receivedTops[%0d] expected %h got %h",
                         $time, i, expected, receivedTops[i]);
                failRun();
            end
        end
    endtask

    // One strobe; the stall must show up on the very next cycle.
    task automatic sendTop(input logic [TOP_WIDTH-1:0] value);
        topIn      = value;
        topInValid = 1'b1;
        nextCycle();
        topInValid  = 1'b0;
        expectedTop = value;
        checkStall(1'b1);
    endtask

    task automatic waitStallFall();
        int cycles;
        cycles = 0;
        while (stallInput) begin
            nextCycle();
            cycles++;
            assert (cycles <= TIMEOUT_CYCLES) else begin
                $display("Timeout at time %0t: stallInput did not fall within %0d cycles.",
                         $time, TIMEOUT_CYCLES);
                failRun();
            end
        end
    endtask

    // Receivers must not move while nothing is being sent.
    task automatic holdFrozen(input int unsigned cycles, input logic expectStall,
                              input logic [TOP_WIDTH-1:0] frozenTop);
        for (int unsigned n = 0; n < cycles; n++) begin
            nextCycle();
            checkStall(expectStall);
            checkReceivers(frozenTop);
        end
    endtask

    task automatic runBusy(input int unsigned cycles);
        for (int unsigned n = 0; n < cycles; n++) begin
            nextCycle();
            checkStall(1'b1); // Still sending, so the source stays stalled.
        end
    endtask

    initial begin
        logic [TOP_WIDTH-1:0] previousTop;
        int unsigned          stretch;

        clk             = 1'b0;
        rst             = 1'b1;
        topIn           = '0;
        topInValid      = 1'b0;
        pipelineIsEmpty = 1'b1;
        rngState        = 32'd32114;
        expectedTop     = '0;

        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // Clean state after reset.
        checkStall(1'b0);
        checkReceivers('0);

        // Plain delivery with the pipeline empty.
        sendTop(randomTop());
        waitStallFall();
        checkReceivers(expectedTop);

        // Busy pipeline beyond warm-up holds the transmitter at its start.
        previousTop     = expectedTop;
        pipelineIsEmpty = 1'b0;
        sendTop(randomTop());
        stretch = randomBetween(WARMUP_CYCLES + 10, WARMUP_CYCLES + 60);
        holdFrozen(stretch, 1'b1, previousTop);
        pipelineIsEmpty = 1'b1;
        waitStallFall();
        checkReceivers(expectedTop);

        // A newer top replaces the one halfway out.
        sendTop(randomTop());
        runBusy(randomBetween(20, 200));
        sendTop(randomTop());
        waitStallFall();
        checkReceivers(expectedTop);

        holdFrozen(randomBetween(5, 60), 1'b0, expectedTop);

        // Back to back, each with its own stretch of busy pipeline at the start.
        for (int t = 0; t < BACK_TO_BACK_TOPS; t++) begin
            previousTop = expectedTop;
            stretch     = randomBetween(0, 40);
            if (stretch > 0) begin
                pipelineIsEmpty = 1'b0;
            end
            sendTop(randomTop());
            holdFrozen(stretch, 1'b1, previousTop);
            pipelineIsEmpty = 1'b1;
            waitStallFall();
            checkReceivers(expectedTop);
            holdFrozen(randomBetween(0, 8), 1'b0, expectedTop);
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
src/topDistPkg.sv
src/delayLine.sv
src/topTransmitter.sv
src/topReceiver.sv
src/topManager.sv
src/topDistribution.sv
verif/topDistributionTb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module topDistributionTb \
    -f flist.f \
    --Mdir obj_dir -o simTopDistribution

# The simulation exits nonzero on a fatal error, so the log decides the result.
./obj_dir/simTopDistribution > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation reported a failure."
    exit 1
fi

if ! grep -q "TEST PASS" sim.log; then
    echo "Simulation ended without a result."
    exit 1
fi
